/* logic/pce_pad_pkg.sv */
// Shared pad types; button bit order follows the host joystick word, not the console wire order
`default_nettype none

package pce_pad_pkg;

	////////////////////////////////////////////////////////////
	// Host side

	// Twelve active-high buttons
	// [3:0] right, left, down, up
	// [7:4] I, II, select, run
	// [11:8] III, IV, V, VI
	typedef logic [11:0] pad_buttons_t;

	typedef logic [7:0] mouse_axis_t;      // Signed movement, two's complement

	////////////////////////////////////////////////////////////
	// Console side

	typedef logic [15:0] pad_word_t;       // Four active-low nibbles per port
	typedef logic [3:0]  pad_nibble_t;     // What the CPU reads back
	typedef logic [2:0]  tap_port_t;       // Multitap port index, saturates at 7

	// Mouse movement nibbles in scan order
	typedef enum logic [1:0] {
		x_high = 2'd0,
		x_low  = 2'd1,
		y_high = 2'd2,
		y_low  = 2'd3
	} mouse_phase_e;

	////////////////////////////////////////////////////////////
	// Constants

	localparam int TAP_PORTS = 5;          // Ports on the multitap

	// Beyond the last port the tap reports no pad
	localparam pad_word_t PAD_IDLE_WORD = 16'h0FFF;

endpackage

`default_nettype wire

/* logic/mouse_delta.sv */
// Expects mouse_stb to toggle once per report and dx/dy to be stable when it does
`timescale 1ns/1ns
`default_nettype none

module mouse_delta import pce_pad_pkg::*; #(
	parameter int mouse_idle_bits = 15
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        pad_clr,
	input  logic        clr_rise,
	input  logic        mouse_stb,
	input  mouse_axis_t mouse_dx,
	input  mouse_axis_t mouse_dy,
	output pad_nibble_t mouse_nibble
);

	logic                       stb_q;
	mouse_axis_t                pend_x, pend_y;    // Last report, not yet shown
	mouse_axis_t                shown_x, shown_y;  // Report the console is reading
	mouse_phase_e               phase;
	logic [mouse_idle_bits-1:0] idle_cnt;
	logic                       idle_done;

	assign idle_done = &idle_cnt;

	////////////////////////////////////////////////////////////
	// Report capture and nibble phase

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stb_q    <= 1'b0;
			pend_x   <= '0;
			pend_y   <= '0;
			shown_x  <= '0;
			shown_y  <= '0;
			phase    <= y_low;
			idle_cnt <= '0;
		end else begin
			stb_q <= mouse_stb;

			// Idle timer, runs only while clear is low
			if (pad_clr)
				idle_cnt <= '0;
			else if (!idle_done)
				idle_cnt <= idle_cnt + 1'b1;

			if (idle_done)
				phase <= y_low;                // Console gave up, restart at x_high

			if (clr_rise) begin
				case (phase)
					x_high:  phase <= x_low;
					x_low:   phase <= y_high;
					y_high:  phase <= y_low;
					default: begin
						phase   <= x_high;
						shown_x <= pend_x;         // New sequence takes the pending report
						shown_y <= pend_y;
						pend_x  <= '0;
						pend_y  <= '0;
					end
				endcase
			end

			// A fresh report overrides the clear above
			if (stb_q ^ mouse_stb) begin
				pend_x <= 8'd0 - mouse_dx;       // Console expects x reversed
				pend_y <= mouse_dy;
			end
		end
	end

	always_comb begin
		case (phase)
			x_high:  mouse_nibble = shown_x[7:4];
			x_low:   mouse_nibble = shown_x[3:0];
			y_high:  mouse_nibble = shown_y[7:4];
			default: mouse_nibble = shown_y[3:0];
		endcase
	end

	// Phase only moves on a clear pulse, the idle timeout or reset
	a_phase_step : assert property (@(posedge clk_sys) disable iff (reset)
		$changed(phase) |-> $past(clr_rise) || $past(idle_done) || $past(reset));

endmodule

`default_nettype wire

/* logic/tap_scanner.sv */
// Scan lines must already be synchronous to clk_sys and held for at least two cycles per level
`timescale 1ns/1ns
`default_nettype none

module tap_scanner import pce_pad_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      pad_sel,
	input  logic      pad_clr,
	input  logic      tap_en,
	input  logic      six_button_en,
	output logic      sel_rise,
	output logic      clr_rise,
	output logic      high_page,
	output tap_port_t port
);

	logic sel_q, clr_q;
	logic sel_edge, clr_edge;

	assign sel_edge = pad_sel & ~sel_q;
	assign clr_edge = pad_clr & ~clr_q;

	////////////////////////////////////////////////////////////
	// Edge pulses, port counter and button page

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q     <= 1'b0;
			clr_q     <= 1'b0;
			sel_rise  <= 1'b0;
			clr_rise  <= 1'b0;
			high_page <= 1'b0;
			port      <= '0;
		end else begin
			sel_q    <= pad_sel;
			clr_q    <= pad_clr;
			sel_rise <= sel_edge;
			clr_rise <= clr_edge;

			if (pad_clr) begin
				port <= '0;                      // Clear restarts the tap scan
				// Six-button pads swap pages on every other clear
				if (clr_edge)
					high_page <= six_button_en & ~high_page;
			end else if (sel_edge && tap_en && port != 3'd7) begin
				port <= port + 3'd1;
			end
		end
	end

	// Edge pulses are single cycle whatever the scan rate
	a_sel_pulse : assert property (@(posedge clk_sys) disable iff (reset)
		sel_rise |=> !sel_rise);
	a_clr_pulse : assert property (@(posedge clk_sys) disable iff (reset)
		clr_rise |=> !clr_rise);

endmodule

`default_nettype wire

/* logic/port_reader.sv */
// Joystick and mouse button inputs are sampled without synchronizers, keep them in the clk_sys domain
`timescale 1ns/1ns
`default_nettype none

module port_reader import pce_pad_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         pad_sel,
	input  logic         pad_clr,
	input  logic         high_page,
	input  logic         mouse_en,
	input  tap_port_t    port,
	input  pad_buttons_t joystick_0,
	input  pad_buttons_t joystick_1,
	input  pad_buttons_t joystick_2,
	input  pad_buttons_t joystick_3,
	input  pad_buttons_t joystick_4,
	input  logic [1:0]   mouse_btn,
	input  pad_nibble_t  mouse_nibble,
	output pad_nibble_t  pad_nibble
);

	pad_buttons_t sel_pad;
	logic [7:0]   mouse_byte;
	pad_word_t    port_word;

	// Host button order to console nibbles, active low
	function automatic pad_word_t pad_format(input pad_buttons_t b);
		pad_format = {4'h0,                      // Nibble 3 reads zero
			~b[11:8],                              // III, IV, V, VI
			~{b[1], b[2], b[0], b[3]},             // Up, right, down, left
			~b[7:4]};                              // I, II, select, run
	endfunction

	////////////////////////////////////////////////////////////
	// Word for the selected port

	always_comb begin
		case (port)
			3'd0:    sel_pad = joystick_0;
			3'd1:    sel_pad = joystick_1;
			3'd2:    sel_pad = joystick_2;
			3'd3:    sel_pad = joystick_3;
			3'd4:    sel_pad = joystick_4;
			default: sel_pad = '0;
		endcase
	end

	// Mouse buttons double up on I and II
	assign mouse_byte = {mouse_nibble,
		~(sel_pad[5] | mouse_btn[1]),
		~(sel_pad[4] | mouse_btn[0]),
		~mouse_btn[1],
		~mouse_btn[0]};

	always_comb begin
		if (port >= TAP_PORTS)
			port_word = PAD_IDLE_WORD;
		else if (port == 3'd0 && mouse_en)
			port_word = {2{mouse_byte}};           // Same byte on both pages
		else
			port_word = pad_format(sel_pad);
	end

	////////////////////////////////////////////////////////////
	// Returned nibble

	always_ff @(posedge clk_sys) begin
		if (reset)
			pad_nibble <= '0;
		else if (pad_clr)
			pad_nibble <= '0;
		else
			pad_nibble <= port_word[{high_page, pad_sel, 2'b00} +: 4];
	end

	// Console sees zero one cycle into any clear
	a_clr_zero : assert property (@(posedge clk_sys) disable iff (reset)
		pad_clr |=> pad_nibble == 4'h0);

endmodule

`default_nettype wire

/* logic/pce_pad_top.sv */
// Configuration levels must not change during a scan, pad_nibble lags the scan lines by two cycles
`timescale 1ns/1ns
`default_nettype none

module pce_pad_top import pce_pad_pkg::*; #(
	parameter int mouse_idle_bits = 15
) (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         pad_sel,
	input  logic         pad_clr,
	input  pad_buttons_t joystick_0,
	input  pad_buttons_t joystick_1,
	input  pad_buttons_t joystick_2,
	input  pad_buttons_t joystick_3,
	input  pad_buttons_t joystick_4,
	input  logic         mouse_stb,
	input  mouse_axis_t  mouse_dx,
	input  mouse_axis_t  mouse_dy,
	input  logic [1:0]   mouse_btn,
	input  logic         tap_en,
	input  logic         six_button_en,
	input  logic         mouse_en,
	output pad_nibble_t  pad_nibble
);

	logic        clr_rise;
	logic        high_page;
	tap_port_t   port;
	pad_nibble_t mouse_nibble;

	////////////////////////////////////////////////////////////
	// Input side

	mouse_delta #(
		.mouse_idle_bits(mouse_idle_bits)
	) mouse_delta0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.pad_clr(pad_clr),
		.clr_rise(clr_rise),
		.mouse_stb(mouse_stb),
		.mouse_dx(mouse_dx),
		.mouse_dy(mouse_dy),
		.mouse_nibble(mouse_nibble)
	);

	////////////////////////////////////////////////////////////
	// Scan tracking

	tap_scanner tap_scanner0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.pad_sel(pad_sel),
		.pad_clr(pad_clr),
		.tap_en(tap_en),
		.six_button_en(six_button_en),
		.sel_rise(),
		.clr_rise(clr_rise),
		.high_page(high_page),
		.port(port)
	);

	////////////////////////////////////////////////////////////
	// Output side

	port_reader port_reader0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.pad_sel(pad_sel),
		.pad_clr(pad_clr),
		.high_page(high_page),
		.mouse_en(mouse_en),
		.port(port),
		.joystick_0(joystick_0),
		.joystick_1(joystick_1),
		.joystick_2(joystick_2),
		.joystick_3(joystick_3),
		.joystick_4(joystick_4),
		.mouse_btn(mouse_btn),
		.mouse_nibble(mouse_nibble),
		.pad_nibble(pad_nibble)
	);

endmodule

`default_nettype wire

/* sim/tb_pad_cases.svh */
// Row table, included inside the testbench module after pce_pad_pkg is imported there

localparam int CASE_MAX = 24;

// cfg is {mouse_en, six_button_en, tap_en}, report is {dx, dy} and zero sends none
typedef struct packed {
	logic [2:0]  cfg;
	logic        new_pads;       // Fresh random buttons on every port
	logic [15:0] report;
	logic [7:0]  idle;           // Cycles with clear low before the clear pulses
	logic [1:0]  clears;
	logic [2:0]  selects;
	logic        sel_level;
	logic        clr_hold;       // Read with clear held high
	logic        from_pad;       // Expect a console nibble of a random pad
	tap_port_t   exp_port;
	logic [1:0]  exp_index;
	pad_nibble_t exp_nibble;     // Literal value when from_pad is clear
} pad_case_t;

pad_case_t cases [0:CASE_MAX-1];
string     case_names [0:CASE_MAX-1];
int        case_count = 0;

task automatic add_row(input string name, input logic [2:0] cfg, input logic new_pads,
	input logic [15:0] report, input logic [7:0] idle, input logic [1:0] clears,
	input logic [2:0] selects, input logic sel_level, input logic clr_hold,
	input logic from_pad, input tap_port_t exp_port, input logic [1:0] exp_index,
	input pad_nibble_t exp_nibble);
	case_names[case_count] = name;
	cases[case_count] = {cfg, new_pads, report, idle, clears, selects, sel_level, clr_hold,
		from_pad, exp_port, exp_index, exp_nibble};
	case_count++;
endtask

// Mouse x shows negated dx, so 13 reads back as ED and 3B as C5
task automatic load_cases();
	//       name               cfg     pads report  idle clr sel lvl hold pad port idx nib
	add_row("clear held",       3'b000, 1, 16'h0000, 0,  1,  0,  1,  1,  0,  0,  0, 4'h0);
	add_row("pad nibble 0",     3'b000, 1, 16'h0000, 0,  1,  0,  0,  0,  1,  0,  0, 4'h0);
	add_row("pad nibble 1",     3'b000, 1, 16'h0000, 0,  1,  0,  1,  0,  1,  0,  1, 4'h0);
	add_row("select no tap",    3'b000, 0, 16'h0000, 0,  1,  3,  1,  0,  1,  0,  1, 4'h0);
	add_row("six page 2",       3'b010, 1, 16'h0000, 0,  1,  0,  0,  0,  1,  0,  2, 4'h0);
	add_row("six page 3",       3'b010, 0, 16'h0000, 0,  2,  0,  1,  0,  1,  0,  3, 4'h0);
	add_row("six page 0",       3'b010, 0, 16'h0000, 0,  1,  0,  0,  0,  1,  0,  0, 4'h0);
	add_row("tap port 1",       3'b001, 1, 16'h0000, 0,  1,  1,  0,  0,  1,  1,  0, 4'h0);
	add_row("tap port 2",       3'b001, 0, 16'h0000, 0,  1,  2,  1,  0,  1,  2,  1, 4'h0);
	add_row("tap port 3",       3'b001, 0, 16'h0000, 0,  1,  3,  0,  0,  1,  3,  0, 4'h0);
	add_row("tap port 4",       3'b001, 0, 16'h0000, 0,  1,  4,  1,  0,  1,  4,  1, 4'h0);
	add_row("tap port 5 low",   3'b001, 0, 16'h0000, 0,  1,  5,  0,  0,  0,  0,  0, 4'hF);
	add_row("tap port 5 high",  3'b001, 0, 16'h0000, 0,  1,  5,  1,  0,  0,  0,  0, 4'hF);
	add_row("mouse x high",     3'b100, 0, 16'h135A, 70, 1,  0,  1,  0,  0,  0,  0, 4'hE);
	add_row("mouse x low",      3'b100, 0, 16'h0000, 0,  1,  0,  1,  0,  0,  0,  0, 4'hD);
	add_row("mouse restart",    3'b100, 0, 16'h3B96, 70, 1,  0,  1,  0,  0,  0,  0, 4'hC);
	add_row("mouse x low 2",    3'b100, 0, 16'h0000, 0,  1,  0,  1,  0,  0,  0,  0, 4'h5);
	add_row("mouse y high",     3'b100, 0, 16'h0000, 0,  1,  0,  1,  0,  0,  0,  0, 4'h9);
	add_row("mouse y low",      3'b100, 0, 16'h0000, 0,  1,  0,  1,  0,  0,  0,  0, 4'h6);
endtask

/* sim/tb_pce_pad.sv */
// Runs the DUT with mouse_idle_bits 6, so the mouse restarts after 63 cycles of clear low
`timescale 1ns/1ns
`default_nettype none

module tb_pce_pad import pce_pad_pkg::*; ();

	localparam int CLK_PERIOD = 8;

	logic         clk_sys = 1'b0;
	logic         reset;
	logic         pad_sel, pad_clr;
	pad_buttons_t pads [0:TAP_PORTS-1];      // joystick_0 to joystick_4
	logic         mouse_stb;
	mouse_axis_t  mouse_dx, mouse_dy;
	logic [1:0]   mouse_btn;
	logic         tap_en, six_button_en, mouse_en;
	pad_nibble_t  pad_nibble;
	int           pass_count = 0;
	int           fail_count = 0;
	int unsigned  seed_draw;

	`include "tb_pad_cases.svh"

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	pce_pad_top #(
		.mouse_idle_bits(6)
	) dut0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.pad_sel(pad_sel),
		.pad_clr(pad_clr),
		.joystick_0(pads[0]),
		.joystick_1(pads[1]),
		.joystick_2(pads[2]),
		.joystick_3(pads[3]),
		.joystick_4(pads[4]),
		.mouse_stb(mouse_stb),
		.mouse_dx(mouse_dx),
		.mouse_dy(mouse_dy),
		.mouse_btn(mouse_btn),
		.tap_en(tap_en),
		.six_button_en(six_button_en),
		.mouse_en(mouse_en),
		.pad_nibble(pad_nibble)
	);

	////////////////////////////////////////////////////////////
	// Reference model and scan helpers

	// Console nibble k of one pad, active low, listed MSB first
	function automatic pad_nibble_t console_nibble(input pad_buttons_t b, input logic [1:0] k);
		case (k)
			2'd0:    console_nibble = ~{b[7], b[6], b[5], b[4]};    // Run, select, II, I
			2'd1:    console_nibble = ~{b[1], b[2], b[0], b[3]};    // Left, down, right, up
			2'd2:    console_nibble = ~{b[11], b[10], b[9], b[8]};  // VI, V, IV, III
			default: console_nibble = 4'h0;
		endcase
	endfunction

	// Falling edges only, with a time limit in case the clock dies
	task automatic wait_falls(input int n);
		time limit;
		int  seen;
		limit = $time + (n + 1) * CLK_PERIOD;
		seen = 0;
		while (seen < n && $time < limit) begin
			@(negedge clk_sys);
			seen++;
		end
		if (seen < n) begin
			$display("Timeout: only %0d of %0d clock edges arrived", seen, n);
			$display("Test FAILED");
			$finish;
		end
	endtask

	// Scan lines hold each level for two cycles
	task automatic drive_scan(input logic sel, input logic clr);
		pad_sel = sel;
		pad_clr = clr;
		wait_falls(2);
	endtask

	task automatic check_nibble(input string name, input pad_nibble_t want);
		if (pad_nibble !== want) begin
			$display("FAIL %0t ns pad_nibble expected %h actual %h", $time, want, pad_nibble);
			fail_count++;
			$display("%s: failed", name);
		end else begin
			pass_count++;
			$display("%s: passed", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// One table row

	task automatic run_case(input int idx);
		pad_case_t   c;
		pad_nibble_t want;
		logic [31:0] draw;
		c = cases[idx];
		{mouse_en, six_button_en, tap_en} = c.cfg;
		pad_clr = 1'b0;
		if (c.new_pads) begin
			foreach (pads[k]) begin
				draw = $urandom;
				pads[k] = draw[11:0];
			end
		end
		if (c.report != 16'h0000) begin
			{mouse_dx, mouse_dy} = c.report;
			mouse_stb = ~mouse_stb;              // One toggle per report
		end
		wait_falls(c.idle);
		repeat (c.clears) begin
			drive_scan(pad_sel, 1'b0);
			drive_scan(1'b1, 1'b1);
			drive_scan(1'b1, 1'b0);
		end
		repeat (c.selects) begin
			drive_scan(1'b0, 1'b0);
			drive_scan(1'b1, 1'b0);             // Rising edge steps the tap
		end
		pad_sel = c.sel_level;
		pad_clr = c.clr_hold;
		wait_falls(3);                         // Two cycles of latency and one spare
		want = c.from_pad ? console_nibble(pads[c.exp_port], c.exp_index) : c.exp_nibble;
		check_nibble(case_names[idx], want);
	endtask

	initial begin
		seed_draw = $urandom(78);
		reset = 1'b1;
		pad_sel = 1'b0;
		pad_clr = 1'b0;
		foreach (pads[k])
			pads[k] = '0;
		mouse_stb = 1'b0;
		mouse_dx = '0;
		mouse_dy = '0;
		mouse_btn = 2'b00;
		tap_en = 1'b0;
		six_button_en = 1'b0;
		mouse_en = 1'b0;
		load_cases();
		wait_falls(4);
		reset = 1'b0;
		check_nibble("after reset", 4'h0);   // Still the reset value here
		for (int i = 0; i < case_count; i++)
			run_case(i);
		$display("%0d checks, %0d passed, %0d failed",
			pass_count + fail_count, pass_count, fail_count);
		if (fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+sim
logic/pce_pad_pkg.sv
logic/mouse_delta.sv
logic/tap_scanner.sv
logic/port_reader.sv
logic/pce_pad_top.sv
sim/tb_pce_pad.sv

/* Bender.yml */
package:
  name: pce_pad

sources:
  - logic/pce_pad_pkg.sv
  - logic/mouse_delta.sv
  - logic/tap_scanner.sv
  - logic/port_reader.sv
  - logic/pce_pad_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_pce_pad.sv
